// File: verilog/fxdiv_pkg.sv
`default_nettype none

package fxdiv_pkg;

    // operand and quotient format, Q21.10
    localparam int data_width = 32;
    localparam int frac_bits  = 10;

    // one quotient bit per iteration
    localparam int num_iter  = data_width + frac_bits;   // 42
    localparam int acc_width = num_iter + 1;              // extra sign bit for the remainder

    // iteration counter must reach num_iter - 1
    localparam int cnt_width = 6;

    // signed 32-bit clamp values
    localparam logic signed [data_width-1:0] max_pos = {1'b0, {(data_width-1){1'b1}}};
    localparam logic signed [data_width-1:0] max_neg = {1'b1, {(data_width-1){1'b0}}};

    typedef enum logic [2:0] {
        st_idle,     // waiting for req
        st_load,     // capture magnitudes
        st_iter,     // non-restoring steps
        st_correct,  // final remainder fix
        st_finish,   // latch signed result
        st_hold      // ack high until req drops
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/div_step_if.sv
`timescale 1ns/100ps
`default_nettype none

interface div_step_if;

    logic load;     // capture operands
    logic step;     // one iteration
    logic correct;  // remainder fix-up
    logic finish;   // latch output
    logic rem_neg;  // partial remainder sign

    modport control (
        output load,
        output step,
        output correct,
        output finish,
        input  rem_neg
    );

    modport datapath (
        input  load,
        input  step,
        input  correct,
        output rem_neg
    );

    // sign_unit only needs the entry and exit strobes
    modport observe (
        input  load,
        input  finish
    );

endinterface

`default_nettype wire

// File: verilog/div_control.sv
`timescale 1ns/100ps
`default_nettype none

module div_control (
    input  logic        clock,
    input  logic        reset,
    input  logic        req,
    input  logic        zero_div,
    input  logic        last_iter,
    output logic        cnt_clear,
    output logic        cnt_en,
    output logic        ack,
    div_step_if.control ctl
);

    import fxdiv_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            state <= next_state;
            ack   <= (state == st_hold) && req;  // drops on the edge req is seen low
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req) begin
                    next_state = st_load;
                end
            end
            st_load: begin
                // zero divisor skips the whole loop
                if (zero_div) begin
                    next_state = st_finish;
                end else begin
                    next_state = st_iter;
                end
            end
            st_iter: begin
                if (last_iter) begin
                    next_state = st_correct;
                end
            end
            st_correct: begin
                next_state = st_finish;
            end
            st_finish: begin
                next_state = st_hold;
            end
            st_hold: begin
                if (!req) begin
                    next_state = st_idle;  // four-phase release
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // strobes decode straight from the state
    assign ctl.load    = (state == st_load);
    assign ctl.step    = (state == st_iter);
    assign ctl.correct = (state == st_correct);
    assign ctl.finish  = (state == st_finish);

    assign cnt_clear = ctl.load;
    assign cnt_en    = ctl.step;

    ack_only_in_hold: assert property (
        @(posedge clock) disable iff (reset)
        ack |-> (state == st_hold)
    );

    no_step_with_load: assert property (
        @(posedge clock) disable iff (reset)
        !(ctl.step && ctl.load)
    );

    // datapath must leave a non-negative remainder after the fix-up
    rem_fixed_after_correct: assert property (
        @(posedge clock) disable iff (reset)
        ctl.correct |=> !ctl.rem_neg
    );

endmodule

`default_nettype wire

// File: verilog/iter_counter.sv
`timescale 1ns/100ps
`default_nettype none

module iter_counter (
    input  logic clock,
    input  logic reset,
    input  logic cnt_clear,
    input  logic cnt_en,
    output logic last_iter
);

    import fxdiv_pkg::*;

    logic [cnt_width-1:0] count;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (cnt_clear) begin
            count <= '0;                // restart on every load
        end else if (cnt_en) begin
            count <= count + 1'b1;
        end
    end

    // high during the final step
    assign last_iter = (count == cnt_width'(num_iter - 1));

    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        cnt_en |-> (count <= cnt_width'(num_iter - 1))
    );

endmodule

`default_nettype wire

// File: verilog/sign_unit.sv
`timescale 1ns/100ps
`default_nettype none

module sign_unit (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [fxdiv_pkg::data_width-1:0] dividend,
    input  logic [fxdiv_pkg::data_width-1:0] divisor,
    input  logic [fxdiv_pkg::num_iter-1:0]   raw_q,
    output logic [fxdiv_pkg::data_width-1:0] mag_dividend,
    output logic [fxdiv_pkg::data_width-1:0] mag_divisor,
    output logic                             zero_div,
    div_step_if.observe                      ctl,
    output logic [fxdiv_pkg::data_width-1:0] quotient,
    output logic                             div_zero
);

    import fxdiv_pkg::*;

    logic                  res_neg;  // operand signs differ
    logic                  dvd_neg;  // picks the clamp on divide by zero
    logic                  zero_q;
    logic [data_width-1:0] sat_q;

    // abs of the most negative value still fits as unsigned
    assign mag_dividend = dividend[data_width-1] ? -dividend : dividend;
    assign mag_divisor  = divisor[data_width-1] ? -divisor : divisor;
    assign zero_div     = (divisor == '0);

    // operands only valid while req is high, so keep what the exit needs
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            res_neg <= 1'b0;
            dvd_neg <= 1'b0;
            zero_q  <= 1'b0;
        end else if (ctl.load) begin
            res_neg <= dividend[data_width-1] ^ divisor[data_width-1];
            dvd_neg <= dividend[data_width-1];
            zero_q  <= zero_div;
        end
    end

    always_comb begin
        if (zero_q) begin
            sat_q = dvd_neg ? max_neg : max_pos;
        end else if (res_neg) begin
            // 2^31 is the largest magnitude a negative result can carry
            if (raw_q > {{(num_iter-data_width){1'b0}}, max_neg}) begin
                sat_q = max_neg;
            end else begin
                sat_q = -raw_q[data_width-1:0];
            end
        end else if (raw_q > {{(num_iter-data_width){1'b0}}, max_pos}) begin
            sat_q = max_pos;
        end else begin
            sat_q = raw_q[data_width-1:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            quotient <= '0;
            div_zero <= 1'b0;
        end else if (ctl.finish) begin
            quotient <= sat_q;   // held until the next finish
            div_zero <= zero_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/nr_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module nr_datapath (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [fxdiv_pkg::data_width-1:0] mag_dividend,
    input  logic [fxdiv_pkg::data_width-1:0] mag_divisor,
    div_step_if.datapath                     ctl,
    output logic [fxdiv_pkg::num_iter-1:0]   raw_q
);

    import fxdiv_pkg::*;

    logic [acc_width-1:0]  rem;         // signed partial remainder
    logic [num_iter-1:0]   qreg;        // dividend bits in, quotient bits out
    logic [data_width-1:0] dvsr;
    logic [acc_width-1:0]  dvsr_ext;
    logic [num_iter-1:0]   dvd_scaled;
    logic [acc_width-1:0]  rem_shift;
    logic [acc_width-1:0]  rem_next;

    // shift into Q.10 and add half the divisor so truncation rounds
    assign dvd_scaled = {mag_dividend, {frac_bits{1'b0}}}
                      + {{(num_iter-data_width+1){1'b0}}, mag_divisor[data_width-1:1]};

    assign dvsr_ext  = {{(acc_width-data_width){1'b0}}, dvsr};
    assign rem_shift = {rem[acc_width-2:0], qreg[num_iter-1]};

    // non-restoring step
    // add back when negative, subtract otherwise
    always_comb begin
        if (rem[acc_width-1]) begin
            rem_next = rem_shift + dvsr_ext;
        end else begin
            rem_next = rem_shift - dvsr_ext;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rem <= '0;
        end else if (ctl.load) begin
            rem <= '0;
        end else if (ctl.step) begin
            rem <= rem_next;
        end else if (ctl.correct && rem[acc_width-1]) begin
            rem <= rem + dvsr_ext;       // restore a negative remainder
        end
    end

    always_ff @(posedge clock) begin
        if (ctl.load) begin
            dvsr <= mag_divisor;
            qreg <= dvd_scaled;
        end else if (ctl.step) begin
            qreg <= {qreg[num_iter-2:0], ~rem_next[acc_width-1]};  // new quotient bit
        end
    end

    assign ctl.rem_neg = rem[acc_width-1];

    // full width kept so sign_unit can see overflow
    assign raw_q = qreg;

endmodule

`default_nettype wire

// File: verilog/fxdiv_top.sv
`timescale 1ns/100ps
`default_nettype none

module fxdiv_top (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             req,
    input  logic [fxdiv_pkg::data_width-1:0] dividend,
    input  logic [fxdiv_pkg::data_width-1:0] divisor,
    output logic                             ack,
    output logic [fxdiv_pkg::data_width-1:0] quotient,
    output logic                             div_zero
);

    import fxdiv_pkg::*;

    logic                  cnt_clear;
    logic                  cnt_en;
    logic                  last_iter;
    logic                  zero_div;
    logic [data_width-1:0] mag_dividend;
    logic [data_width-1:0] mag_divisor;
    logic [num_iter-1:0]   raw_q;

    div_step_if u_step_if ();   // strobes and remainder sign

    div_control u_div_control (
        .clock     (clock),
        .reset     (reset),
        .req       (req),
        .zero_div  (zero_div),
        .last_iter (last_iter),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .ack       (ack),
        .ctl       (u_step_if.control)
    );

    iter_counter u_iter_counter (
        .clock     (clock),
        .reset     (reset),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .last_iter (last_iter)
    );

    sign_unit u_sign_unit (
        .clock        (clock),
        .reset        (reset),
        .dividend     (dividend),
        .divisor      (divisor),
        .raw_q        (raw_q),
        .mag_dividend (mag_dividend),
        .mag_divisor  (mag_divisor),
        .zero_div     (zero_div),
        .ctl          (u_step_if.observe),
        .quotient     (quotient),
        .div_zero     (div_zero)
    );

    nr_datapath u_nr_datapath (
        .clock        (clock),
        .reset        (reset),
        .mag_dividend (mag_dividend),
        .mag_divisor  (mag_divisor),
        .ctl          (u_step_if.datapath),
        .raw_q        (raw_q)
    );

endmodule

`default_nettype wire

// File: verif/fxdiv_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fxdiv_checker (
    input  logic        clock,
    input  logic        reset,
    input  logic        req,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    input  logic        ack,
    input  logic [31:0] quotient,
    input  logic        div_zero,
    input  logic [31:0] test_num,
    input  logic        exp_valid,
    input  logic [31:0] exp_quotient,
    input  logic        exp_div_zero,
    output logic [31:0] error_count,
    output logic [31:0] test_count
);

    logic        ack_prev;
    logic        req_prev;
    logic [31:0] held_q;   // result seen when ack rose
    logic        held_dz;

    // Q21.10 divide, half away from zero, clamped to 32 bits
    function automatic logic [31:0] model_quotient(input logic [31:0] dvd,
                                                   input logic [31:0] dvs);
        logic signed [63:0] n;
        logic signed [63:0] d;
        logic [63:0]        q;
        if (dvs == 32'h0) begin
            return dvd[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        n = $signed(dvd);
        d = $signed(dvs);
        n = (n < 0) ? -n : n;
        d = (d < 0) ? -d : d;
        q = ((n <<< 10) + (d >>> 1)) / d;  // half the divisor rounds the truncation
        if (dvd[31] ^ dvs[31]) begin
            return (q > 64'h8000_0000) ? 32'h8000_0000 : 32'(-q);
        end
        return (q > 64'h7fff_ffff) ? 32'h7fff_ffff : q[31:0];
    endfunction

    always @(posedge clock or posedge reset) begin
        logic [31:0] exp_q;
        logic        bad;
        if (reset) begin
            error_count = 0;
            test_count  = 0;
            ack_prev    = 1'b0;
            req_prev    = 1'b0;
            held_q      = '0;
            held_dz     = 1'b0;
        end else begin
            // ack is registered from the req seen one edge earlier
            if (ack && !ack_prev && !req_prev) begin
                $display("handshake violation: ack rose while req was low");
                error_count++;
            end else if (ack && !ack_prev) begin
                exp_q = model_quotient(dividend, divisor);
                bad   = 1'b0;
                if (quotient !== exp_q) begin
                    $display("** Error test %0d: quotient = %h, expected %h", test_num, quotient,
                             exp_q);
                    bad = 1'b1;
                end
                if (div_zero !== (divisor == 32'h0)) begin
                    $display("** Error test %0d: div_zero = %h, expected %h", test_num, div_zero,
                             divisor == 32'h0);
                    bad = 1'b1;
                end
                if (exp_valid && (quotient !== exp_quotient || div_zero !== exp_div_zero)) begin
                    $display("** Error test %0d: quotient = %h div_zero = %h, table has %h %h",
                             test_num, quotient, div_zero, exp_quotient, exp_div_zero);
                    bad = 1'b1;
                end
                test_count++;
                if (bad) begin
                    error_count++;
                end
                $display("test %0d %s: %h / %h = %h, div_zero %h", test_num, bad ? "FAIL" : "pass",
                         dividend, divisor, quotient, div_zero);
                held_q  = quotient;
                held_dz = div_zero;
            end else if (ack && ack_prev && !req_prev) begin
                $display("handshake violation: ack still high a cycle after req dropped");
                error_count++;
            end else if (ack && ack_prev) begin
                if (quotient !== held_q) begin
                    $display("** Error test %0d: quotient = %h while ack held, was %h", test_num,
                             quotient, held_q);
                    error_count++;
                end
                if (div_zero !== held_dz) begin
                    $display("** Error test %0d: div_zero = %h while ack held, was %h", test_num,
                             div_zero, held_dz);
                    error_count++;
                end
            end
            ack_prev = ack;
            req_prev = req;
        end
    end

endmodule

`default_nettype wire

// File: verif/fxdiv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fxdiv_tb;

    localparam int ack_timeout     = 100;  // a normal divide takes 46 cycles
    localparam int release_timeout = 10;
    localparam int num_random      = 30;

    logic        clock;
    logic        reset;
    logic        req;
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic        ack;
    logic [31:0] quotient;
    logic        div_zero;
    logic [31:0] test_num;
    logic        exp_valid;
    logic [31:0] exp_quotient;
    logic        exp_div_zero;
    logic [31:0] error_count;
    logic [31:0] test_count;
    logic [31:0] lfsr;
    int          tb_errors;
    int          rows_done;

    // stimulus table, one entry per test
    logic [31:0] tbl_dividend[$];
    logic [31:0] tbl_divisor[$];
    int          tbl_hold[$];       // extra cycles req stays high after ack
    logic        tbl_exp_valid[$];  // random rows are covered by the model only
    logic [31:0] tbl_exp_q[$];
    logic        tbl_exp_dz[$];
    string       tbl_tag[$];

    fxdiv_top u_fxdiv_top (.*);

    fxdiv_checker u_checker (.*);

    always #5 clock = ~clock;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_word(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic add_row(input logic [31:0] dvd, input logic [31:0] dvs, input int hold,
                           input logic [31:0] exp_q, input logic exp_dz, input string tag);
        tbl_dividend.push_back(dvd);
        tbl_divisor.push_back(dvs);
        tbl_hold.push_back(hold);
        tbl_exp_valid.push_back(1'b1);
        tbl_exp_q.push_back(exp_q);
        tbl_exp_dz.push_back(exp_dz);
        tbl_tag.push_back(tag);
    endtask

    task automatic fill_table();
        logic [31:0] dvd;
        logic [31:0] dvs;
        add_row(32'h0000_1800, 32'h0000_0800, 0, 32'h0000_0c00, 1'b0, "6.0 / 2.0");
        add_row(32'hffff_e800, 32'h0000_0800, 0, 32'hffff_f400, 1'b0, "-6.0 / 2.0");
        add_row(32'h0000_1800, 32'hffff_f800, 0, 32'hffff_f400, 1'b0, "6.0 / -2.0");
        add_row(32'hffff_e800, 32'hffff_f800, 0, 32'h0000_0c00, 1'b0, "-6.0 / -2.0");
        add_row(32'h0000_0001, 32'h0000_0800, 0, 32'h0000_0001, 1'b0, "half lsb up");
        add_row(32'hffff_ffff, 32'h0000_0800, 0, 32'hffff_ffff, 1'b0, "half lsb down");
        add_row(32'h0000_0003, 32'h0000_0800, 0, 32'h0000_0002, 1'b0, "1.5 lsb");
        add_row(32'h0000_0003, 32'hffff_f800, 0, 32'hffff_fffe, 1'b0, "-1.5 lsb");
        add_row(32'h0000_0001, 32'h0000_0801, 0, 32'h0000_0000, 1'b0, "just under half");
        add_row(32'h0000_0001, 32'h0000_07ff, 0, 32'h0000_0001, 1'b0, "just over half");
        add_row(32'h7fff_ffff, 32'h0000_0001, 0, 32'h7fff_ffff, 1'b0, "saturate positive");
        add_row(32'h8000_0000, 32'h0000_0001, 0, 32'h8000_0000, 1'b0, "saturate negative");
        add_row(32'h4000_0000, 32'hffff_ffff, 0, 32'h8000_0000, 1'b0, "saturate neg divisor");
        add_row(32'h8000_0000, 32'h0000_0400, 0, 32'h8000_0000, 1'b0, "exact most negative");
        add_row(32'h8000_0000, 32'hffff_fc00, 0, 32'h7fff_ffff, 1'b0, "overflow by one");
        add_row(32'h0000_1000, 32'h0000_0000, 0, 32'h7fff_ffff, 1'b1, "zero divisor pos");
        add_row(32'hffff_f000, 32'h0000_0000, 3, 32'h8000_0000, 1'b1, "zero divisor neg");
        add_row(32'h0000_1800, 32'h0000_0800, 0, 32'h0000_0c00, 1'b0, "after zero divisor");
        add_row(32'h0000_2800, 32'h0000_1000, 6, 32'h0000_0a00, 1'b0, "back-pressure");
        for (int i = 0; i < num_random; i++) begin
            take_word(dvd);
            take_word(dvs);
            add_row(dvd, dvs, i % 3, 32'h0, 1'b0, "random");
            tbl_exp_valid[tbl_exp_valid.size()-1] = 1'b0;
        end
    endtask

    task automatic run_row(input int idx, output bit timed_out);
        int waited;
        timed_out = 1'b0;
        @(posedge clock);
        #1;
        dividend     = tbl_dividend[idx];
        divisor      = tbl_divisor[idx];
        exp_valid    = tbl_exp_valid[idx];
        exp_quotient = tbl_exp_q[idx];
        exp_div_zero = tbl_exp_dz[idx];
        test_num     = idx;
        req          = 1'b1;
        waited       = 0;
        while (!ack && waited < ack_timeout) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (!ack) begin
            $display("timeout: no ack within %0d cycles on test %0d (%s)", ack_timeout, idx,
                     tbl_tag[idx]);
            tb_errors++;
            timed_out = 1'b1;
        end else begin
            repeat (tbl_hold[idx]) begin
                @(posedge clock);
                #1;
            end
            req    = 1'b0;
            waited = 0;
            while (ack && waited < release_timeout) begin
                @(posedge clock);
                #1;
                waited++;
            end
            if (ack) begin
                $display("timeout: ack did not fall after req dropped on test %0d (%s)", idx,
                         tbl_tag[idx]);
                tb_errors++;
                timed_out = 1'b1;
            end else begin
                rows_done++;
            end
        end
    endtask

    initial begin
        bit timed_out;
        clock        = 1'b0;
        reset        = 1'b1;
        req          = 1'b0;
        dividend     = '0;
        divisor      = '0;
        test_num     = '0;
        exp_valid    = 1'b0;
        exp_quotient = '0;
        exp_div_zero = 1'b0;
        lfsr         = 32'ha0f8_4649;
        tb_errors    = 0;
        rows_done    = 0;
        timed_out    = 1'b0;
        fill_table();
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (5) @(posedge clock);  // req idle, checker flags any ack
        for (int i = 0; i < tbl_dividend.size() && !timed_out; i++) begin
            run_row(i, timed_out);
        end
        repeat (3) @(posedge clock);
        if (!timed_out && test_count != rows_done) begin
            $display("checker saw %0d results for %0d tests", test_count, rows_done);
            tb_errors++;
        end
        $display("tests %0d, errors %0d", rows_done, tb_errors + error_count);
        if (tb_errors == 0 && error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/fxdiv_pkg.sv
verilog/div_step_if.sv
verilog/div_control.sv
verilog/iter_counter.sv
verilog/sign_unit.sv
verilog/nr_datapath.sv
verilog/fxdiv_top.sv
verif/fxdiv_checker.sv
verif/fxdiv_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fxdiv_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
